// ==== hdl/exu_alu_pkg.sv ====
// Decode-info bit map for the ALU cluster; BJP and regular fields overlap and bit 0 picks the group
`default_nettype none

package exu_alu_pkg;

  //////////////////////////////////////////////////
  // Common
  localparam int INFO_WIDTH   = 12;  // Decode-info vector width
  localparam int INFO_GRP_BJP = 0;   // 1 = branch/jump group

  //////////////////////////////////////////////////
  // Branch/jump group fields
  localparam int INFO_BJP_JUMP  = 1;  // jal or jalr
  localparam int INFO_BJP_BXX   = 2;  // Any conditional branch
  localparam int INFO_BJP_BPRDT = 3;  // Predicted taken
  localparam int INFO_BJP_BEQ   = 4;
  localparam int INFO_BJP_BNE   = 5;
  localparam int INFO_BJP_BLT   = 6;
  localparam int INFO_BJP_BGE   = 7;  // Greater or equal, signed
  localparam int INFO_BJP_BLTU  = 8;
  localparam int INFO_BJP_BGEU  = 9;  // Greater or equal, unsigned

  //////////////////////////////////////////////////
  // Regular group fields
  localparam int INFO_RGLR_OP2IMM = 1;  // Immediate as second operand
  localparam int INFO_RGLR_ADD    = 2;
  localparam int INFO_RGLR_SUB    = 3;
  localparam int INFO_RGLR_SLT    = 4;
  localparam int INFO_RGLR_SLTU   = 5;
  localparam int INFO_RGLR_XOR    = 6;
  localparam int INFO_RGLR_OR     = 7;
  localparam int INFO_RGLR_AND    = 8;
  localparam int INFO_RGLR_SLL    = 9;
  localparam int INFO_RGLR_SRL    = 10;
  localparam int INFO_RGLR_SRA    = 11;  // Arithmetic right shift

endpackage

`default_nettype wire

// ==== hdl/exu_alu_disp.sv ====
// Steers one instruction per cycle by the group bit; i_info must be stable while i_valid is high
`timescale 1ns/1ps
`default_nettype none

module exu_alu_disp
  import exu_alu_pkg::*;
(
  // Upstream handshake
  input  logic                  i_valid,
  input  logic [INFO_WIDTH-1:0] i_info,
  output logic                  i_ready,

  // Regular unit
  output logic                  rglr_i_valid,
  input  logic                  rglr_i_ready,

  // Branch/jump unit
  output logic                  bjp_i_valid,
  input  logic                  bjp_i_ready,

  // Datapath owner
  output logic                  dp_sel_bjp
);

  logic grp_bjp;

  assign grp_bjp = i_info[INFO_GRP_BJP];  // Group decode

  // Only the chosen unit sees valid
  assign bjp_i_valid  = i_valid & grp_bjp;
  assign rglr_i_valid = i_valid & ~grp_bjp;

  // Ready comes back from the same unit
  assign i_ready = grp_bjp ? bjp_i_ready : rglr_i_ready;

  // BJP owns the shared datapath for its instructions
  assign dp_sel_bjp = grp_bjp;

endmodule

`default_nettype wire

// ==== hdl/exu_alu_rglr.sv ====
// Regular ALU ops only; an info vector with no op bit set flags err and leaves wdat undefined
`timescale 1ns/1ps
`default_nettype none

module exu_alu_rglr
  import exu_alu_pkg::*;
#(
  parameter int XLEN = 32
) (
  // Issue handshake
  input  logic                  rglr_i_valid,
  output logic                  rglr_i_ready,
  input  logic [XLEN-1:0]       rglr_i_rs1,
  input  logic [XLEN-1:0]       rglr_i_rs2,
  input  logic [XLEN-1:0]       rglr_i_imm,
  input  logic [INFO_WIDTH-1:0] rglr_i_info,

  // Commit side
  output logic                  rglr_o_valid,
  input  logic                  rglr_o_ready,
  output logic [XLEN-1:0]       rglr_o_wbck_wdat,
  output logic                  rglr_o_wbck_err,

  // Shared datapath request
  output logic [XLEN-1:0]       rglr_req_alu_op1,
  output logic [XLEN-1:0]       rglr_req_alu_op2,
  output logic                  rglr_req_alu_add,
  output logic                  rglr_req_alu_sub,
  output logic                  rglr_req_alu_slt,
  output logic                  rglr_req_alu_sltu,
  output logic                  rglr_req_alu_xor,
  output logic                  rglr_req_alu_or,
  output logic                  rglr_req_alu_and,
  output logic                  rglr_req_alu_sll,
  output logic                  rglr_req_alu_srl,
  output logic                  rglr_req_alu_sra,
  input  logic [XLEN-1:0]       rglr_req_alu_res
);

  logic op2imm;
  logic any_op;

  assign op2imm = rglr_i_info[INFO_RGLR_OP2IMM];

  // Operands
  assign rglr_req_alu_op1 = rglr_i_rs1;
  assign rglr_req_alu_op2 = op2imm ? rglr_i_imm : rglr_i_rs2;

  // One-hot op strobes straight from decode
  assign rglr_req_alu_add  = rglr_i_info[INFO_RGLR_ADD];
  assign rglr_req_alu_sub  = rglr_i_info[INFO_RGLR_SUB];
  assign rglr_req_alu_slt  = rglr_i_info[INFO_RGLR_SLT];
  assign rglr_req_alu_sltu = rglr_i_info[INFO_RGLR_SLTU];
  assign rglr_req_alu_xor  = rglr_i_info[INFO_RGLR_XOR];
  assign rglr_req_alu_or   = rglr_i_info[INFO_RGLR_OR];
  assign rglr_req_alu_and  = rglr_i_info[INFO_RGLR_AND];
  assign rglr_req_alu_sll  = rglr_i_info[INFO_RGLR_SLL];
  assign rglr_req_alu_srl  = rglr_i_info[INFO_RGLR_SRL];
  assign rglr_req_alu_sra  = rglr_i_info[INFO_RGLR_SRA];

  assign any_op = |rglr_i_info[INFO_RGLR_SRA:INFO_RGLR_ADD];  // Op field span

  // Pass-through handshake and combinational result
  assign rglr_o_valid     = rglr_i_valid;
  assign rglr_i_ready     = rglr_o_ready;
  assign rglr_o_wbck_wdat = rglr_req_alu_res;
  assign rglr_o_wbck_err  = ~any_op;  // Illegal encoding

endmodule

`default_nettype wire

// ==== hdl/exu_alu_bjp.sv ====
// Resolves branches and links jumps; no target address here, and PC_SIZE must not exceed XLEN
`timescale 1ns/1ps
`default_nettype none

module exu_alu_bjp
  import exu_alu_pkg::*;
#(
  parameter int XLEN    = 32,
  parameter int PC_SIZE = 32
) (
  // Issue handshake
  input  logic                  bjp_i_valid,
  output logic                  bjp_i_ready,
  input  logic [XLEN-1:0]       bjp_i_rs1,
  input  logic [XLEN-1:0]       bjp_i_rs2,
  input  logic [PC_SIZE-1:0]    bjp_i_pc,
  input  logic [INFO_WIDTH-1:0] bjp_i_info,

  // Commit side
  output logic                  bjp_o_valid,
  input  logic                  bjp_o_ready,
  output logic [XLEN-1:0]       bjp_o_wbck_wdat,  // Link address
  output logic                  bjp_o_wbck_err,
  output logic                  bjp_o_cmt_bjp,
  output logic                  bjp_o_cmt_prdt,   // Predicted taken
  output logic                  bjp_o_cmt_rslv,   // Resolved taken

  // Shared datapath request
  output logic [XLEN-1:0]       bjp_req_alu_op1,
  output logic [XLEN-1:0]       bjp_req_alu_op2,
  output logic                  bjp_req_alu_cmp_eq,
  output logic                  bjp_req_alu_cmp_ne,
  output logic                  bjp_req_alu_cmp_lt,
  output logic                  bjp_req_alu_cmp_ge,
  output logic                  bjp_req_alu_cmp_ltu,
  output logic                  bjp_req_alu_cmp_geu,
  output logic                  bjp_req_alu_add,
  input  logic                  bjp_req_alu_cmp_res,
  input  logic [XLEN-1:0]       bjp_req_alu_add_res
);

  logic jump;
  logic bxx;
  logic [XLEN-1:0] pc_ext;

  assign jump   = bjp_i_info[INFO_BJP_JUMP];
  assign bxx    = bjp_i_info[INFO_BJP_BXX];
  assign pc_ext = XLEN'(bjp_i_pc);  // Zero-extend pc

  // Jump links pc + 4, branch compares rs1 against rs2
  assign bjp_req_alu_op1 = jump ? pc_ext : bjp_i_rs1;
  assign bjp_req_alu_op2 = jump ? XLEN'(4) : bjp_i_rs2;
  assign bjp_req_alu_add = jump;

  assign bjp_req_alu_cmp_eq  = bjp_i_info[INFO_BJP_BEQ];
  assign bjp_req_alu_cmp_ne  = bjp_i_info[INFO_BJP_BNE];
  assign bjp_req_alu_cmp_lt  = bjp_i_info[INFO_BJP_BLT];
  assign bjp_req_alu_cmp_ge  = bjp_i_info[INFO_BJP_BGE];
  assign bjp_req_alu_cmp_ltu = bjp_i_info[INFO_BJP_BLTU];
  assign bjp_req_alu_cmp_geu = bjp_i_info[INFO_BJP_BGEU];

  // Handshake passes through
  assign bjp_o_valid = bjp_i_valid;
  assign bjp_i_ready = bjp_o_ready;

  assign bjp_o_wbck_wdat = bjp_req_alu_add_res;  // Only meaningful for jumps
  assign bjp_o_wbck_err  = ~(jump | bxx);        // Neither kind set
  assign bjp_o_cmt_bjp   = jump | bxx;
  assign bjp_o_cmt_prdt  = bjp_i_info[INFO_BJP_BPRDT];
  assign bjp_o_cmt_rslv  = jump | bjp_req_alu_cmp_res;  // Jumps always taken

endmodule

`default_nettype wire

// ==== hdl/exu_alu_dpath.sv ====
// Single shared datapath; requests are one-hot per owner and results are valid the same cycle
`timescale 1ns/1ps
`default_nettype none

module exu_alu_dpath #(
  parameter int XLEN = 32
) (
  input  logic            dp_sel_bjp,  // 1 = BJP owns the datapath

  // Regular unit request
  input  logic [XLEN-1:0] rglr_req_alu_op1,
  input  logic [XLEN-1:0] rglr_req_alu_op2,
  input  logic            rglr_req_alu_add,
  input  logic            rglr_req_alu_sub,
  input  logic            rglr_req_alu_slt,
  input  logic            rglr_req_alu_sltu,
  input  logic            rglr_req_alu_xor,
  input  logic            rglr_req_alu_or,
  input  logic            rglr_req_alu_and,
  input  logic            rglr_req_alu_sll,
  input  logic            rglr_req_alu_srl,
  input  logic            rglr_req_alu_sra,

  // BJP unit request
  input  logic [XLEN-1:0] bjp_req_alu_op1,
  input  logic [XLEN-1:0] bjp_req_alu_op2,
  input  logic            bjp_req_alu_cmp_eq,
  input  logic            bjp_req_alu_cmp_ne,
  input  logic            bjp_req_alu_cmp_lt,
  input  logic            bjp_req_alu_cmp_ge,
  input  logic            bjp_req_alu_cmp_ltu,
  input  logic            bjp_req_alu_cmp_geu,
  input  logic            bjp_req_alu_add,

  // Results to both units
  output logic [XLEN-1:0] add_res,
  output logic            cmp_res,
  output logic [XLEN-1:0] alu_res
);

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] op1, op2;
  logic op_add, op_sub, op_slt, op_sltu, op_xor, op_or, op_and, op_sll, op_srl, op_sra;
  logic cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu;
  logic op_unsgn, op_invb;
  logic [XLEN:0] adder_a, adder_b, adder_sum;
  logic lt_flag, eq_flag;
  logic [SHW-1:0] shamt;
  logic [XLEN-1:0] shin, shout, sll_res, sra_mask;

  //////////////////////////////////////////////////
  // Owner mux
  assign op1     = dp_sel_bjp ? bjp_req_alu_op1 : rglr_req_alu_op1;
  assign op2     = dp_sel_bjp ? bjp_req_alu_op2 : rglr_req_alu_op2;
  assign op_add  = dp_sel_bjp ? bjp_req_alu_add : rglr_req_alu_add;
  assign op_sub  = ~dp_sel_bjp & rglr_req_alu_sub;
  assign op_slt  = ~dp_sel_bjp & rglr_req_alu_slt;
  assign op_sltu = ~dp_sel_bjp & rglr_req_alu_sltu;
  assign op_xor  = ~dp_sel_bjp & rglr_req_alu_xor;
  assign op_or   = ~dp_sel_bjp & rglr_req_alu_or;
  assign op_and  = ~dp_sel_bjp & rglr_req_alu_and;
  assign op_sll  = ~dp_sel_bjp & rglr_req_alu_sll;
  assign op_srl  = ~dp_sel_bjp & rglr_req_alu_srl;
  assign op_sra  = ~dp_sel_bjp & rglr_req_alu_sra;
  assign cmp_eq  = dp_sel_bjp & bjp_req_alu_cmp_eq;
  assign cmp_ne  = dp_sel_bjp & bjp_req_alu_cmp_ne;
  assign cmp_lt  = dp_sel_bjp & bjp_req_alu_cmp_lt;
  assign cmp_ge  = dp_sel_bjp & bjp_req_alu_cmp_ge;
  assign cmp_ltu = dp_sel_bjp & bjp_req_alu_cmp_ltu;
  assign cmp_geu = dp_sel_bjp & bjp_req_alu_cmp_geu;

  //////////////////////////////////////////////////
  // Adder with one extra bit so the sign of op1 - op2 never overflows
  assign op_unsgn = op_sltu | cmp_ltu | cmp_geu;  // Zero-extend instead of sign-extend
  assign op_invb  = ~op_add;                      // Every other user subtracts

  assign adder_a   = {~op_unsgn & op1[XLEN-1], op1};
  assign adder_b   = {~op_unsgn & op2[XLEN-1], op2};
  assign adder_sum = adder_a + (op_invb ? ~adder_b : adder_b) + (XLEN+1)'(op_invb);

  assign lt_flag = adder_sum[XLEN];            // op1 < op2
  assign eq_flag = ~|adder_sum[XLEN-1:0];      // Zero difference
  assign add_res = adder_sum[XLEN-1:0];

  assign cmp_res = (cmp_eq & eq_flag) | (cmp_ne & ~eq_flag)
                 | ((cmp_lt | cmp_ltu) & lt_flag)
                 | ((cmp_ge | cmp_geu) & ~lt_flag);

  //////////////////////////////////////////////////
  // Right shifter with left shift by bit reversal around it
  assign shamt    = op2[SHW-1:0];
  assign sra_mask = ~({XLEN{1'b1}} >> shamt);  // Fill bits for sra

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      shin[i] = op_sll ? op1[XLEN-1-i] : op1[i];
    end
    shout = shin >> shamt;
    for (int i = 0; i < XLEN; i++) begin
      sll_res[i] = shout[XLEN-1-i];
    end
  end

  // Regular result from one-hot strobes
  assign alu_res = ({XLEN{op_add | op_sub}}   & add_res)
                 | ({XLEN{op_slt | op_sltu}}  & XLEN'(lt_flag))
                 | ({XLEN{op_xor}}            & (op1 ^ op2))
                 | ({XLEN{op_or}}             & (op1 | op2))
                 | ({XLEN{op_and}}            & (op1 & op2))
                 | ({XLEN{op_sll}}            & sll_res)
                 | ({XLEN{op_srl}}            & shout)
                 | ({XLEN{op_sra}}            & (shout | (sra_mask & {XLEN{op1[XLEN-1]}})));

endmodule

`default_nettype wire

// ==== hdl/exu_alu_cmt.sv ====
// One-entry commit register; at most one unit valid per cycle and results held while stalled
`timescale 1ns/1ps
`default_nettype none

module exu_alu_cmt #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,

  // Regular unit result
  input  logic            rglr_o_valid,
  input  logic [XLEN-1:0] rglr_o_wbck_wdat,
  input  logic            rglr_o_wbck_err,

  // BJP unit result
  input  logic            bjp_o_valid,
  input  logic [XLEN-1:0] bjp_o_wbck_wdat,
  input  logic            bjp_o_wbck_err,
  input  logic            bjp_o_cmt_bjp,
  input  logic            bjp_o_cmt_prdt,
  input  logic            bjp_o_cmt_rslv,

  output logic            cmt_in_ready,  // Shared by both units

  // Commit output
  output logic            o_valid,
  input  logic            o_ready,
  output logic [XLEN-1:0] o_wbck_wdat,
  output logic            o_wbck_err,
  output logic            o_cmt_bjp,
  output logic            o_cmt_prdt,
  output logic            o_cmt_rslv
);

  logic in_valid;
  logic load;

  assign in_valid     = rglr_o_valid | bjp_o_valid;
  assign cmt_in_ready = ~o_valid | o_ready;  // Empty or draining this edge
  assign load         = in_valid & cmt_in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
    end else if (cmt_in_ready) begin
      o_valid <= in_valid;  // Refill or go empty
    end
  end

  // Payload where regular results carry no branch info
  always_ff @(posedge clk) begin
    if (load) begin
      o_wbck_wdat <= bjp_o_valid ? bjp_o_wbck_wdat : rglr_o_wbck_wdat;
      o_wbck_err  <= bjp_o_valid ? bjp_o_wbck_err : rglr_o_wbck_err;
      o_cmt_bjp   <= bjp_o_valid & bjp_o_cmt_bjp;
      o_cmt_prdt  <= bjp_o_valid & bjp_o_cmt_prdt;
      o_cmt_rslv  <= bjp_o_valid & bjp_o_cmt_rslv;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/exu_alu.sv ====
// ALU cluster top; PC_SIZE must not exceed XLEN and payload must hold while i_valid waits on i_ready
`timescale 1ns/1ps
`default_nettype none

module exu_alu
  import exu_alu_pkg::*;
#(
  parameter int XLEN    = 32,
  parameter int PC_SIZE = 32
) (
  input  logic                  clk,
  input  logic                  rst,

  // Issue
  input  logic                  i_valid,
  output logic                  i_ready,
  input  logic [XLEN-1:0]       i_rs1,
  input  logic [XLEN-1:0]       i_rs2,
  input  logic [XLEN-1:0]       i_imm,
  input  logic [PC_SIZE-1:0]    i_pc,
  input  logic [INFO_WIDTH-1:0] i_info,

  // Commit
  output logic                  o_valid,
  input  logic                  o_ready,
  output logic [XLEN-1:0]       o_wbck_wdat,
  output logic                  o_wbck_err,
  output logic                  o_cmt_bjp,
  output logic                  o_cmt_prdt,
  output logic                  o_cmt_rslv
);

  //////////////////////////////////////////////////
  // Internal nets named after the ports they join
  logic rglr_i_valid, rglr_i_ready, bjp_i_valid, bjp_i_ready, dp_sel_bjp, cmt_in_ready;
  logic rglr_o_valid, rglr_o_wbck_err;
  logic bjp_o_valid, bjp_o_wbck_err, bjp_o_cmt_bjp, bjp_o_cmt_prdt, bjp_o_cmt_rslv;
  logic [XLEN-1:0] rglr_o_wbck_wdat, bjp_o_wbck_wdat;
  logic [XLEN-1:0] rglr_req_alu_op1, rglr_req_alu_op2, bjp_req_alu_op1, bjp_req_alu_op2;
  logic rglr_req_alu_add, rglr_req_alu_sub, rglr_req_alu_slt, rglr_req_alu_sltu;
  logic rglr_req_alu_xor, rglr_req_alu_or, rglr_req_alu_and;
  logic rglr_req_alu_sll, rglr_req_alu_srl, rglr_req_alu_sra;
  logic bjp_req_alu_cmp_eq, bjp_req_alu_cmp_ne, bjp_req_alu_cmp_lt, bjp_req_alu_cmp_ge;
  logic bjp_req_alu_cmp_ltu, bjp_req_alu_cmp_geu, bjp_req_alu_add;
  logic [XLEN-1:0] add_res, alu_res;
  logic cmp_res;

  exu_alu_disp exu_alu_disp_i (.*);  // Group steering

  exu_alu_rglr #(.XLEN(XLEN)) exu_alu_rglr_i (
    .rglr_i_rs1       (i_rs1),
    .rglr_i_rs2       (i_rs2),
    .rglr_i_imm       (i_imm),
    .rglr_i_info      (i_info),
    .rglr_o_ready     (cmt_in_ready),
    .rglr_req_alu_res (alu_res),
    .*
  );

  exu_alu_bjp #(.XLEN(XLEN), .PC_SIZE(PC_SIZE)) exu_alu_bjp_i (
    .bjp_i_rs1           (i_rs1),
    .bjp_i_rs2           (i_rs2),
    .bjp_i_pc            (i_pc),
    .bjp_i_info          (i_info),
    .bjp_o_ready         (cmt_in_ready),
    .bjp_req_alu_cmp_res (cmp_res),
    .bjp_req_alu_add_res (add_res),
    .*
  );

  exu_alu_dpath #(.XLEN(XLEN)) exu_alu_dpath_i (.*);  // Shared adder and shifter

  exu_alu_cmt #(.XLEN(XLEN)) exu_alu_cmt_i (.*);      // Commit register

endmodule

`default_nettype wire

// ==== tests/exu_alu_assertions.sv ====
// Bound into exu_alu; relies on its internal nets rglr_o_valid and cmt_in_ready
`timescale 1ns/1ps
`default_nettype none

module exu_alu_assertions #(
  parameter int XLEN = 32
) (
  input logic            clk,
  input logic            rst,
  input logic            i_valid,
  input logic            i_ready,
  input logic            o_valid,
  input logic            o_ready,
  input logic [XLEN-1:0] o_wbck_wdat,
  input logic            o_wbck_err,
  input logic            o_cmt_bjp,
  input logic            o_cmt_prdt,
  input logic            o_cmt_rslv,
  input logic            rglr_o_valid,  // Regular result offered
  input logic            cmt_in_ready
);

  // Empty right after reset
  a_reset_empty: assert property (@(posedge clk) rst |=> !o_valid)
    else $error("o_valid high in the cycle after reset");

  // Stalled result holds
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    o_valid && !o_ready |=> o_valid && $stable(o_wbck_wdat) && $stable(o_wbck_err)
      && $stable(o_cmt_bjp) && $stable(o_cmt_prdt) && $stable(o_cmt_rslv))
    else $error("commit output changed while stalled");

  a_rglr_no_bjp: assert property (@(posedge clk) disable iff (rst)
    rglr_o_valid && cmt_in_ready |=> !o_cmt_bjp)  // Load from regular unit
    else $error("o_cmt_bjp set on a regular result");

  // Accepted instruction shows up one cycle later
  a_one_cycle: assert property (@(posedge clk) disable iff (rst)
    i_valid && i_ready |=> o_valid)
    else $error("accepted instruction did not reach o_valid after one cycle");

  // Room in the register means the issue side is open
  a_ready_open: assert property (@(posedge clk) disable iff (rst)
    (!o_valid || o_ready) |-> i_ready)
    else $error("i_ready low while the commit register can take a result");

endmodule

bind exu_alu exu_alu_assertions #(.XLEN(XLEN)) exu_alu_assertions_i (
  .clk          (clk),
  .rst          (rst),
  .i_valid      (i_valid),
  .i_ready      (i_ready),
  .o_valid      (o_valid),
  .o_ready      (o_ready),
  .o_wbck_wdat  (o_wbck_wdat),
  .o_wbck_err   (o_wbck_err),
  .o_cmt_bjp    (o_cmt_bjp),
  .o_cmt_prdt   (o_cmt_prdt),
  .o_cmt_rslv   (o_cmt_rslv),
  .rglr_o_valid (rglr_o_valid),
  .cmt_in_ready (cmt_in_ready)
);

`default_nettype wire

// ==== tests/tb_exu_alu.sv ====
// Runs exu_alu at XLEN 32 from tests/exu_alu_vectors.txt and must be started from the project root
`timescale 1ns/1ps
`default_nettype none

module tb_exu_alu
  import exu_alu_pkg::*;
;

  localparam int XLEN    = 32;
  localparam int PC_SIZE = 32;
  localparam int WORDS   = 11;  // Words per vector line
  localparam int MAX_VEC = 64;

  logic                  clk;
  logic                  rst;
  logic                  i_valid;
  logic                  i_ready;
  logic [XLEN-1:0]       i_rs1;
  logic [XLEN-1:0]       i_rs2;
  logic [XLEN-1:0]       i_imm;
  logic [PC_SIZE-1:0]    i_pc;
  logic [INFO_WIDTH-1:0] i_info;
  logic                  o_valid;
  logic                  o_ready;
  logic [XLEN-1:0]       o_wbck_wdat;
  logic                  o_wbck_err;
  logic                  o_cmt_bjp;
  logic                  o_cmt_prdt;
  logic                  o_cmt_rslv;

  logic [31:0] vec_mem [0:WORDS*MAX_VEC-1];
  int          exp_q[$];  // Accepted vector indices in issue order
  int          num_vec;
  int          errors;
  int          checks;
  int          results;
  int          cycles;
  int          limit;     // 0 until vectors are counted
  logic [15:0] lfsr;

  exu_alu #(.XLEN(XLEN), .PC_SIZE(PC_SIZE)) exu_alu_i (.*);

  //////////////////////////////////////////////////
  // Helpers
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic issue_vector(input int n);
    int base;
    base    = n * WORDS;
    i_info  = vec_mem[base][INFO_WIDTH-1:0];
    i_rs1   = vec_mem[base+1];
    i_rs2   = vec_mem[base+2];
    i_imm   = vec_mem[base+3];
    i_pc    = vec_mem[base+4];
    i_valid = 1'b1;
    do @(negedge clk); while (!i_ready);  // Payload held until accepted
    exp_q.push_back(n);
    @(posedge clk);
    #1;
  endtask

  task automatic check_result(input int n);
    int base;
    base = n * WORDS;
    if (vec_mem[base+10][0]) begin
      check_value("o_wbck_wdat", o_wbck_wdat, vec_mem[base+5]);
    end
    check_value("o_wbck_err", 32'(o_wbck_err), vec_mem[base+6]);
    check_value("o_cmt_bjp", 32'(o_cmt_bjp), vec_mem[base+7]);
    check_value("o_cmt_prdt", 32'(o_cmt_prdt), vec_mem[base+8]);
    check_value("o_cmt_rslv", 32'(o_cmt_rslv), vec_mem[base+9]);
  endtask

  //////////////////////////////////////////////////
  // Clock, back-pressure, monitor, watchdog
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    o_ready = 1'b0;
    lfsr    = 16'd11450;
    @(negedge rst);
    forever begin
      @(posedge clk);
      #1;
      o_ready = lfsr[0];  // One bit per step
      lfsr    = lfsr_next(lfsr);
    end
  end

  // Sampled mid-cycle where handshake and result are settled
  initial begin
    forever begin
      @(negedge clk);
      if (rst === 1'b0 && o_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result appeared with no instruction outstanding");
        end else if (o_ready) begin
          check_result(exp_q.pop_front());
          results++;
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (limit == 0 || cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", limit);
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  initial begin
    errors  = 0;
    checks  = 0;
    results = 0;
    num_vec = 0;
    limit   = 0;
    rst     = 1'b1;
    i_valid = 1'b0;
    i_rs1   = '0;
    i_rs2   = '0;
    i_imm   = '0;
    i_pc    = '0;
    i_info  = '0;
    for (int a = 0; a < WORDS*MAX_VEC; a++) begin
      vec_mem[a] = ~32'(a);  // Upper bits set marks an unread word
    end
    $readmemh("tests/exu_alu_vectors.txt", vec_mem);
    while (num_vec < MAX_VEC && vec_mem[num_vec*WORDS][31:INFO_WIDTH] == '0) begin
      num_vec++;
    end
    limit = 20 * num_vec + 50;

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (3) @(posedge clk);  // Idle with nothing coming out
    #1;

    for (int n = 0; n < num_vec; n++) begin
      issue_vector(n);
    end
    i_valid = 1'b0;
    wait (results == num_vec);
    repeat (3) @(posedge clk);  // Room for a stray extra result

    if (num_vec == 0) begin
      errors++;
      $display("No vectors were read from the vector file");
    end
    $display("Vectors %0d, checks %0d, errors %0d", num_vec, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/exu_alu_vectors.txt ====
// info rs1 rs2 imm pc, then expected wdat err cmt_bjp prdt rslv
// and a last flag that is 1 where wdat is checked
004 00000005 00000003 00000000 00000000 00000008 0 0 0 0 1 // add
006 7fffffff 12345678 00000001 00000000 80000000 0 0 0 0 1 // addi overflow
008 00000003 00000005 00000000 00000000 fffffffe 0 0 0 0 1 // sub
010 ffffffff 00000001 00000000 00000000 00000001 0 0 0 0 1 // slt
020 ffffffff 00000001 00000000 00000000 00000000 0 0 0 0 1 // sltu
042 f0f0f0f0 00000000 0ff00ff0 00000000 ff00ff00 0 0 0 0 1 // xori
080 12340000 00005678 00000000 00000000 12345678 0 0 0 0 1 // or
102 deadbeef 00000000 0000ffff 00000000 0000beef 0 0 0 0 1 // andi
202 00000001 00000000 0000001f 00000000 80000000 0 0 0 0 1 // slli 31
400 80000000 00000004 00000000 00000000 08000000 0 0 0 0 1 // srl
802 80000000 00000000 00000004 00000000 f8000000 0 0 0 0 1 // srai
002 00000011 00000022 00000033 00000000 00000000 1 0 0 0 0 // no regular op
015 80000000 80000000 00000000 00000100 00000000 0 1 0 1 0 // beq
02d 80000000 7fffffff 00000000 00000104 00000000 0 1 1 1 0 // bne predicted
045 80000000 7fffffff 00000000 00000108 00000000 0 1 0 1 0 // blt
08d 80000000 7fffffff 00000000 0000010c 00000000 0 1 1 0 0 // bge predicted
105 80000000 7fffffff 00000000 00000110 00000000 0 1 0 0 0 // bltu
205 80000000 7fffffff 00000000 00000114 00000000 0 1 0 1 0 // bgeu
003 00000000 00000000 00000000 00001000 00001004 0 1 0 1 1 // jal
003 0000abcd 00000000 00000000 fffffffc 00000000 0 1 0 1 1 // jalr wraps
001 00000005 00000006 00000000 00000200 00000000 1 0 0 0 0 // no branch kind

// ==== flist.f ====
hdl/exu_alu_pkg.sv
hdl/exu_alu_disp.sv
hdl/exu_alu_rglr.sv
hdl/exu_alu_bjp.sv
hdl/exu_alu_dpath.sv
hdl/exu_alu_cmt.sv
hdl/exu_alu.sv
tests/exu_alu_assertions.sv
tests/tb_exu_alu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exu_alu
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
